// ==== project.f ====
hw/cpuPkg.sv
hw/mult.sv
hw/alu.sv
hw/regFile.sv
hw/operandFetch.sv
hw/execCore.sv
verification/tbExecCore.sv

// ==== Makefile ====
SIM := obj_dir/simExecCore

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): project.f hw/*.sv verification/*.sv
	verilator --binary --timing --assert -j 0 --top-module tbExecCore -f project.f -o simExecCore

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== verification/tbExecCore.sv ====
// directed tests for execCore; the model expects in-order results exactly one cycle after issue
`timescale 1ns/10ps

module tbExecCore import cpuPkg::*; ();

	localparam int CLK_PERIOD_NS   = 4;
	localparam int CYCLES_PER_TEST = 40;
	localparam int TEST_COUNT      = 6;
	localparam int TIMEOUT_NS      = CLK_PERIOD_NS * CYCLES_PER_TEST * TEST_COUNT;

	logic   CLK = 1'b0;
	logic   RSTb;
	logic   issue;
	instr_t instr;
	word_t  result;
	logic   resultValid;
	flags_t flags;

	word_t       regModel [REG_COUNT]; // mirror of the register file
	flags_t      flagModel;
	logic [31:0] rngState;
	int          errCount;
	int          testErrStart;
	int          testsRun;
	int          testsFailed;

	execCore i_dut (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.issue       (issue),
		.instr       (instr),
		.result      (result),
		.resultValid (resultValid),
		.flags       (flags)
	);

	always #(CLK_PERIOD_NS / 2) CLK = ~CLK;

	// xorshift32
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic flags_t flagsFor(input word_t v, input logic c);
		flags_t f;
		f.sign  = v[15];
		f.carry = c;
		f.zero  = (v == 16'd0);
		return f;
	endfunction

	function automatic aluOp_e chainOp(input logic [2:0] sel);
		case (sel)
			3'd0: return ADD;
			3'd1: return SUB;
			3'd2: return XOR;
			3'd3: return AND;
			3'd4: return OR;
			3'd5: return ADC;
			3'd6: return LSL;
			default: return MOV;
		endcase
	endfunction

	// expected value, flags and write decision of one operation
	task automatic modelAlu(input aluOp_e op, input word_t a, input word_t b, input flags_t f,
			output word_t v, output flags_t nf, output logic we);
		logic [16:0] sAdd;
		logic [16:0] sSub;
		logic [31:0] p;
		logic        cin;
		cin  = (op == ADC || op == SBB) ? f.carry : 1'b0;
		sAdd = {1'b0, a} + {1'b0, b} + {16'd0, cin};
		sSub = {1'b0, a} - {1'b0, b} - {16'd0, cin}; // bit 16 is the borrow
		p    = {16'd0, a} * {16'd0, b};
		we   = op inside {MOV, ADD, ADC, SUB, SBB, AND, OR, XOR, MUL, MULU,
			ASR, LSR, LSL, ROLC, RORC, SAVEF};
		case (op)
			MOV:       v = b;
			ADD, ADC:  v = sAdd[15:0];
			SUB, SBB:  v = sSub[15:0];
			AND:       v = a & b;
			OR:        v = a | b;
			XOR:       v = a ^ b;
			MUL:       v = p[15:0];
			MULU:      v = p[31:16];
			CMP, TEST: v = a;
			ASR:       v = {b[15], b[15:1]};
			LSR:       v = {1'b0, b[15:1]};
			LSL:       v = {b[14:0], 1'b0};
			ROLC:      v = {b[14:0], f.carry};
			RORC:      v = {f.carry, b[15:1]};
			SAVEF:     v = {13'd0, f};
			default:   v = '0; // flag ops, RESTF and reserved
		endcase
		nf = f;
		case (op)
			ADD, ADC:                nf = flagsFor(v, sAdd[16]);
			SUB, SBB, CMP:           nf = flagsFor(sSub[15:0], sSub[16]);
			AND, OR, XOR, MUL, MULU: nf = flagsFor(v, 1'b0);
			TEST:                    nf.zero = ((a & b) == 16'd0);
			ASR, LSR, LSL:           nf.zero = (v == 16'd0);
			ROLC:                    nf.carry = a[15];
			RORC:                    nf.carry = a[0];
			CLC:                     nf.carry = 1'b0;
			STC:                     nf.carry = 1'b1;
			CLZ:                     nf.zero = 1'b0;
			STZ:                     nf.zero = 1'b1;
			CLS:                     nf.sign = 1'b0;
			STS:                     nf.sign = 1'b1;
			RESTF:                   nf = flags_t'(b[2:0]);
			default:                 nf = f;
		endcase
	endtask

	// runs one instruction on the mirror and returns what the DUT should show
	task automatic predict(input instr_t cmd, output word_t v, output flags_t f);
		word_t  a;
		word_t  b;
		logic   we;
		a = regModel[cmd.rd];
		b = cmd.useImm ? cmd.imm : regModel[cmd.rs];
		modelAlu(cmd.op, a, b, flagModel, v, f, we);
		flagModel = f;
		if (we) begin
			regModel[cmd.rd] = v;
		end
	endtask

	task automatic checkWord(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			errCount++;
			$display("ERR %0t ns %s: expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkFlags(input string name, input flags_t expected, input flags_t actual);
		if (actual !== expected) begin
			errCount++;
			$display("ERR %0t ns %s (scz): expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errCount++;
			$display("ERR %0t ns %s: expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic beginTest();
		testErrStart = errCount;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errCount == testErrStart) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errCount - testErrStart);
		end
	endtask

	task automatic applyReset();
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;
	endtask

	// issue one instruction alone and check it one cycle later
	task automatic runOp(input aluOp_e op, input regAddr_t rd, input regAddr_t rs,
			input logic useImm, input word_t imm);
		instr_t cmd;
		word_t  expVal;
		flags_t expFlags;
		cmd.op     = op;
		cmd.rd     = rd;
		cmd.rs     = rs;
		cmd.useImm = useImm;
		cmd.imm    = imm;
		predict(cmd, expVal, expFlags);
		@(posedge CLK);
		issue <= 1'b1;
		instr <= cmd;
		@(posedge CLK);
		issue <= 1'b0;
		@(negedge CLK);
		checkBit("resultValid", 1'b1, resultValid);
		checkWord("result", expVal, result);
		checkFlags("flags", expFlags, flags);
	endtask

	task automatic movImm(input regAddr_t rd, input word_t value);
		runOp(MOV, rd, 4'd0, 1'b1, value);
	endtask

	task automatic opReg(input aluOp_e op, input regAddr_t rd, input regAddr_t rs);
		runOp(op, rd, rs, 1'b0, '0);
	endtask

	task automatic opOnCopy(input aluOp_e op);
		opReg(MOV, 4'd6, 4'd1); // r6 = a, r2 holds b
		opReg(op, 4'd6, 4'd2);
	endtask

	task automatic testReset();
		beginTest();
		@(negedge CLK);
		checkBit("resultValid", 1'b0, resultValid);
		checkFlags("flags", '0, flags);
		checkWord("result", '0, result);
		for (int i = 0; i < REG_COUNT; i++) begin
			opReg(MOV, 4'd0, regAddr_t'(i));
		end
		endTest("reset");
	endtask

	task automatic testArith();
		word_t a;
		word_t b;
		beginTest();
		for (int i = 0; i < 2; i++) begin
			a = word_t'(nextRandom());
			b = word_t'(nextRandom());
			movImm(4'd1, a);
			movImm(4'd2, b);
			movImm(4'd3, a);
			opReg(ADD, 4'd3, 4'd2);
			opReg(ADC, 4'd3, 4'd2); // carry in from the ADD
			movImm(4'd4, a);
			opReg(SUB, 4'd4, 4'd2);
			opReg(SBB, 4'd4, 4'd2);
			opReg(CMP, 4'd1, 4'd2);
			opReg(MOV, 4'd5, 4'd1); // r1 untouched by CMP
		end
		movImm(4'd1, 16'h8000);
		opReg(ADD, 4'd1, 4'd1); // wraps to zero with carry out
		opReg(CMP, 4'd2, 4'd2);
		endTest("arith");
	endtask

	task automatic testLogic();
		word_t a;
		word_t b;
		beginTest();
		a = word_t'(nextRandom());
		b = word_t'(nextRandom());
		movImm(4'd1, a);
		movImm(4'd2, b);
		opReg(TEST, 4'd1, 4'd2);
		opOnCopy(AND);
		opOnCopy(OR);
		opOnCopy(XOR);
		opOnCopy(MUL);
		opOnCopy(MULU);
		movImm(4'd2, ~a); // no common bits
		opReg(TEST, 4'd1, 4'd2);
		opOnCopy(AND);
		movImm(4'd2, '0);
		opOnCopy(MUL);
		endTest("logic");
	endtask

	task automatic testShift();
		word_t v;
		beginTest();
		v = word_t'(nextRandom());
		movImm(4'd1, v);
		movImm(4'd2, ~v); // opposite bits keep A and B apart
		opReg(STC, 4'd0, 4'd0);
		opReg(ROLC, 4'd1, 4'd2);
		opReg(RORC, 4'd1, 4'd2);
		opReg(CLC, 4'd0, 4'd0);
		opReg(ROLC, 4'd1, 4'd2);
		opReg(RORC, 4'd1, 4'd2);
		opReg(ASR, 4'd1, 4'd2);
		opReg(LSR, 4'd1, 4'd2);
		opReg(LSL, 4'd1, 4'd2);
		movImm(4'd1, 16'h0001);
		opReg(LSR, 4'd1, 4'd1); // shifts out to zero
		endTest("shift");
	endtask

	task automatic testFlags();
		beginTest();
		opReg(STS, 4'd0, 4'd0);
		opReg(STC, 4'd0, 4'd0);
		opReg(STZ, 4'd0, 4'd0);
		opReg(SAVEF, 4'd1, 4'd0);
		opReg(CLS, 4'd1, 4'd0);
		opReg(CLC, 4'd1, 4'd0);
		opReg(CLZ, 4'd1, 4'd0);
		opReg(SAVEF, 4'd2, 4'd0);
		runOp(RESTF, 4'd1, 4'd0, 1'b1, 16'h0005);
		opReg(SAVEF, 4'd3, 4'd0);
		opReg(BSR, 4'd1, 4'd1);
		opReg(BSL, 4'd1, 4'd1);
		opReg(aluOp_e'(5'd14), 4'd1, 4'd1);
		opReg(aluOp_e'(5'd15), 4'd1, 4'd1);
		opReg(ROL, 4'd1, 4'd1);
		opReg(ROR, 4'd1, 4'd1);
		opReg(RSV31, 4'd1, 4'd1);
		opReg(MOV, 4'd4, 4'd1); // r1 kept its saved flags
		endTest("flags");
	endtask

	// one instruction per cycle, each reading the previous destination
	task automatic testChain();
		instr_t      cmd;
		word_t       expVal;
		word_t       prevVal;
		flags_t      expFlags;
		flags_t      prevFlags;
		regAddr_t    lastRd;
		logic [31:0] r;
		beginTest();
		lastRd    = 4'd8;
		expVal    = '0;
		expFlags  = '0;
		for (int i = 0; i <= 14; i++) begin
			@(posedge CLK);
			if (i < 14) begin
				r          = nextRandom();
				cmd.imm    = r[15:0];
				cmd.useImm = (i < 4) || (i % 5 == 0); // imm must beat a forward
				cmd.op     = (i < 4) ? MOV : chainOp(r[18:16]);
				if (i < 4) begin
					cmd.rd = regAddr_t'(8 + i);
					cmd.rs = 4'd8;
				end else if (i % 2 == 0) begin
					cmd.rd = lastRd;
					cmd.rs = {2'b10, r[20:19]};
				end else begin
					cmd.rd = {2'b10, r[20:19]};
					cmd.rs = lastRd;
				end
				lastRd = cmd.rd;
				predict(cmd, expVal, expFlags);
				issue <= 1'b1;
				instr <= cmd;
			end else begin
				issue <= 1'b0;
			end
			@(negedge CLK);
			if (i > 0) begin
				checkBit("resultValid", 1'b1, resultValid);
				checkWord("result", prevVal, result);
				checkFlags("flags", prevFlags, flags);
			end
			prevVal   = expVal;
			prevFlags = expFlags;
		end
		@(negedge CLK);
		checkBit("resultValid", 1'b0, resultValid); // pulse ends after the last issue
		endTest("chain");
	endtask

	initial begin
		RSTb         = 1'b0;
		issue        = 1'b0;
		instr        = '0;
		rngState     = 32'hcd17456f;
		flagModel    = '0;
		errCount     = 0;
		testErrStart = 0;
		testsRun     = 0;
		testsFailed  = 0;
		for (int i = 0; i < REG_COUNT; i++) begin
			regModel[i] = '0;
		end
		applyReset();
		testReset();
		testArith();
		testLogic();
		testShift();
		testFlags();
		testChain();
		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// guards against a hung run
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: tests did not finish within %0d ns", TIMEOUT_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== hw/execCore.sv ====
// execute core top; one instruction per cycle, no stall input, result and flags one cycle after issue
`timescale 1ns/10ps

module execCore import cpuPkg::*; (
	input  logic   CLK,
	input  logic   RSTb,
	input  logic   issue,
	input  instr_t instr,
	output word_t  result,
	output logic   resultValid,
	output flags_t flags
);

	regAddr_t rdAddrA;
	regAddr_t rdAddrB;
	regAddr_t wrAddr;
	word_t    rdDataA;
	word_t    rdDataB;
	word_t    opA;
	word_t    opB;
	aluRes_t  aluRes;
	logic     wrEn;

	assign wrEn        = aluRes.valid && aluRes.writeEn;
	assign result      = aluRes.value;
	assign resultValid = aluRes.valid;

	regFile i_regs (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (aluRes.value)
	);

	operandFetch i_fetch (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.instr   (instr),
		.issue   (issue),
		.res     (aluRes),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrAddr  (wrAddr),
		.opA     (opA),
		.opB     (opB)
	);

	alu i_alu (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.a       (opA),
		.b       (opB),
		.op      (instr.op),
		.execute (issue),
		.res     (aluRes),
		.flags   (flags)
	);

endmodule

// ==== hw/operandFetch.sv ====
// operand select with one-deep forwarding; assumes the ALU result lands exactly one cycle after issue
`timescale 1ns/10ps

module operandFetch import cpuPkg::*; (
	input  logic     CLK,
	input  logic     RSTb,
	input  instr_t   instr,
	input  logic     issue,
	input  aluRes_t  res,
	output regAddr_t rdAddrA,
	output regAddr_t rdAddrB,
	input  word_t    rdDataA,
	input  word_t    rdDataB,
	output regAddr_t wrAddr,
	output word_t    opA,
	output word_t    opB
);

	regAddr_t pendAddr;
	logic     fwdOk;
	logic     fwdA;
	logic     fwdB;

	assign rdAddrA = instr.rd;
	assign rdAddrB = instr.rs;
	assign wrAddr  = pendAddr; // destination of the instruction now in the ALU

	// result in flight that has not reached the register file yet
	assign fwdOk = res.valid && res.writeEn;
	assign fwdA  = fwdOk && (instr.rd == pendAddr);
	assign fwdB  = fwdOk && (instr.rs == pendAddr);

	assign opA = fwdA ? res.value : rdDataA;

	always_comb begin
		if (instr.useImm) begin
			opB = instr.imm; // immediate wins over any forward
		end else if (fwdB) begin
			opB = res.value;
		end else begin
			opB = rdDataB;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pendAddr <= '0;
		end else if (issue) begin
			pendAddr <= instr.rd;
		end
	end

	// a forward is only legal for an instruction issued on the previous edge
	aFwdOnValid: assert property (@(posedge CLK) disable iff (!RSTb)
		(fwdA || fwdB) |-> (res.valid && $past(issue)))
		else $error("operandFetch: forward without a result in flight");

endmodule

// ==== hw/regFile.sv ====
// register file with two asynchronous reads and one write; a read in the write cycle sees the old word
`timescale 1ns/10ps

module regFile import cpuPkg::*; (
	input  logic     CLK,
	input  logic     RSTb,
	input  regAddr_t rdAddrA,
	input  regAddr_t rdAddrB,
	output word_t    rdDataA,
	output word_t    rdDataB,
	input  logic     wrEn,
	input  regAddr_t wrAddr,
	input  word_t    wrData
);

	word_t regs [REG_COUNT];

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0; // all registers start at zero
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// a write address coming back from the pending tracker must be resolved
	aWrAddrKnown: assert property (@(posedge CLK) disable iff (!RSTb)
		wrEn |-> !$isunknown(wrAddr))
		else $error("regFile: write with unknown address");

endmodule

// ==== hw/alu.sv ====
// flag-holding ALU; result, flags and writeEn only change on execute, valid follows execute each cycle
`timescale 1ns/10ps

module alu import cpuPkg::*; (
	input  logic    CLK,
	input  logic    RSTb,
	input  word_t   a,
	input  word_t   b,
	input  aluOp_e  op,
	input  logic    execute,
	output aluRes_t res,
	output flags_t  flags
);

	logic [WORD_BITS:0]     addExt;
	logic [WORD_BITS:0]     subExt;
	logic [2*WORD_BITS-1:0] mulFull;
	logic                   carryIn;
	word_t                  andVal;
	word_t                  orVal;
	word_t                  xorVal;
	word_t                  asrVal;
	word_t                  lsrVal;
	word_t                  lslVal;
	word_t                  rolcVal;
	word_t                  rorcVal;
	word_t                  nextVal;
	flags_t                 nextFlags;
	logic                   nextWe;

	// sign, carry and zero of a fresh result
	function automatic flags_t resultFlags(input word_t v, input logic c);
		return '{sign: v[WORD_BITS-1], carry: c, zero: (v == '0)};
	endfunction

	assign carryIn = (op == ADC || op == SBB) ? flags.carry : 1'b0;
	assign addExt  = {1'b0, a} + {1'b0, b} + {{WORD_BITS{1'b0}}, carryIn};
	assign subExt  = {1'b0, a} - {1'b0, b} - {{WORD_BITS{1'b0}}, carryIn}; // msb is borrow

	assign andVal  = a & b;
	assign orVal   = a | b;
	assign xorVal  = a ^ b;
	assign asrVal  = {b[WORD_BITS-1], b[WORD_BITS-1:1]};
	assign lsrVal  = {1'b0, b[WORD_BITS-1:1]};
	assign lslVal  = {b[WORD_BITS-2:0], 1'b0};
	assign rolcVal = {b[WORD_BITS-2:0], flags.carry};
	assign rorcVal = {flags.carry, b[WORD_BITS-1:1]};

	mult i_mult (
		.a       (a),
		.b       (b),
		.product (mulFull)
	);

	always_comb begin
		nextVal   = '0;
		nextFlags = flags; // unchanged unless the op says otherwise
		nextWe    = 1'b0;
		case (op)
			MOV: begin
				nextVal = b;
				nextWe  = 1'b1;
			end
			ADD, ADC: begin
				nextVal   = addExt[WORD_BITS-1:0];
				nextFlags = resultFlags(addExt[WORD_BITS-1:0], addExt[WORD_BITS]);
				nextWe    = 1'b1;
			end
			SUB, SBB: begin
				nextVal   = subExt[WORD_BITS-1:0];
				nextFlags = resultFlags(subExt[WORD_BITS-1:0], subExt[WORD_BITS]);
				nextWe    = 1'b1;
			end
			AND: begin
				nextVal   = andVal;
				nextFlags = resultFlags(andVal, 1'b0);
				nextWe    = 1'b1;
			end
			OR: begin
				nextVal   = orVal;
				nextFlags = resultFlags(orVal, 1'b0);
				nextWe    = 1'b1;
			end
			XOR: begin
				nextVal   = xorVal;
				nextFlags = resultFlags(xorVal, 1'b0);
				nextWe    = 1'b1;
			end
			MUL: begin
				nextVal   = mulFull[WORD_BITS-1:0];
				nextFlags = resultFlags(mulFull[WORD_BITS-1:0], 1'b0);
				nextWe    = 1'b1;
			end
			MULU: begin
				nextVal   = mulFull[2*WORD_BITS-1:WORD_BITS];
				nextFlags = resultFlags(mulFull[2*WORD_BITS-1:WORD_BITS], 1'b0);
				nextWe    = 1'b1;
			end
			CMP: begin
				nextVal   = a;
				nextFlags = resultFlags(subExt[WORD_BITS-1:0], subExt[WORD_BITS]);
			end
			TEST: begin
				nextVal         = a;
				nextFlags.zero  = (andVal == '0);
			end
			ASR: begin
				nextVal        = asrVal;
				nextFlags.zero = (asrVal == '0);
				nextWe         = 1'b1;
			end
			LSR: begin
				nextVal        = lsrVal;
				nextFlags.zero = (lsrVal == '0);
				nextWe         = 1'b1;
			end
			LSL: begin
				nextVal        = lslVal;
				nextFlags.zero = (lslVal == '0);
				nextWe         = 1'b1;
			end
			ROLC: begin
				nextVal         = rolcVal;
				nextFlags.carry = a[WORD_BITS-1];
				nextWe          = 1'b1;
			end
			RORC: begin
				nextVal         = rorcVal;
				nextFlags.carry = a[0];
				nextWe          = 1'b1;
			end
			CLC: nextFlags.carry = 1'b0;
			STC: nextFlags.carry = 1'b1;
			CLZ: nextFlags.zero  = 1'b0;
			STZ: nextFlags.zero  = 1'b1;
			CLS: nextFlags.sign  = 1'b0;
			STS: nextFlags.sign  = 1'b1;
			SAVEF: begin
				nextVal = {{(WORD_BITS-$bits(flags_t)){1'b0}}, flags};
				nextWe  = 1'b1;
			end
			RESTF: nextFlags = flags_t'(b[$bits(flags_t)-1:0]);
			BSR, BSL, ROL, ROR, RSV31: ; // reserved, zero result
			default: ;                  // 14 and 15 also reserved
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			res   <= '0;
			flags <= '0;
		end else begin
			res.valid <= execute;
			if (execute) begin
				res.value   <= nextVal;
				res.writeEn <= nextWe;
				flags       <= nextFlags;
			end
		end
	end

	aValidKnown: assert property (@(posedge CLK) disable iff (!RSTb)
		!$isunknown(res.valid))
		else $error("alu: res.valid is unknown");

endmodule

// ==== hw/mult.sv ====
// purely combinational unsigned multiplier; long ripple path, so keep the clock slow or add stages
`timescale 1ns/10ps

module mult import cpuPkg::*; (
	input  word_t                  a,
	input  word_t                  b,
	output logic [2*WORD_BITS-1:0] product
);

	logic [2*WORD_BITS-1:0] aWide;

	assign aWide = {{WORD_BITS{1'b0}}, a}; // zero extend before shifting

	// one partial product per bit of b
	always_comb begin
		product = '0;
		for (int i = 0; i < WORD_BITS; i++) begin
			if (b[i]) begin
				product = product + (aWide << i);
			end
		end
	end

endmodule

// ==== hw/cpuPkg.sv ====
// shared types for the 16-bit execute core; opcodes 14 and 15 have no enum name and act as reserved
package cpuPkg;

	localparam int WORD_BITS     = 16;
	localparam int REG_COUNT     = 16;
	localparam int REG_ADDR_BITS = 4;

	typedef logic [WORD_BITS-1:0]     word_t;
	typedef logic [REG_ADDR_BITS-1:0] regAddr_t;

	// numbering fixed by the instruction encoding
	typedef enum logic [4:0] {
		MOV   = 5'd0,
		ADD   = 5'd1,
		ADC   = 5'd2,  // add with carry in
		SUB   = 5'd3,
		SBB   = 5'd4,  // subtract with borrow in
		AND   = 5'd5,
		OR    = 5'd6,
		XOR   = 5'd7,
		MUL   = 5'd8,  // low half of product
		MULU  = 5'd9,  // high half of product
		BSR   = 5'd10, // reserved
		BSL   = 5'd11, // reserved
		CMP   = 5'd12, // flags of A - B, no write
		TEST  = 5'd13, // zero of A & B, no write
		ASR   = 5'd16,
		LSR   = 5'd17,
		LSL   = 5'd18,
		ROLC  = 5'd19, // rotate left through carry
		RORC  = 5'd20, // rotate right through carry
		ROL   = 5'd21, // reserved
		ROR   = 5'd22, // reserved
		CLC   = 5'd23,
		STC   = 5'd24,
		CLZ   = 5'd25,
		STZ   = 5'd26,
		CLS   = 5'd27,
		STS   = 5'd28,
		SAVEF = 5'd29, // flags into bits 2..0 of result
		RESTF = 5'd30, // flags from bits 2..0 of B
		RSV31 = 5'd31  // reserved
	} aluOp_e;

	// same bit order as SAVEF and RESTF
	typedef struct packed {
		logic sign;
		logic carry;
		logic zero;
	} flags_t;

	typedef struct packed {
		aluOp_e   op;
		regAddr_t rd;     // destination and operand A
		regAddr_t rs;     // operand B when useImm is low
		logic     useImm;
		word_t    imm;
	} instr_t;

	typedef struct packed {
		logic  valid;   // one cycle after issue
		logic  writeEn; // result goes to the register file
		word_t value;
	} aluRes_t;

endpackage
